// File: design/fabric.sv
// ------------------------------------------------
// System fabric top level: two masters to five
// slave ports through one crossbar
// ------------------------------------------------

`timescale 1ns/100ps

module fabric (
	input  logic                      clk,
	input  logic                      i_reset,
	input  fabric_ocp_pkg::ocp_req_t  i_instr_req,	// instruction master
	output fabric_ocp_pkg::ocp_rsp_t  o_instr_rsp,
	input  fabric_ocp_pkg::ocp_req_t  i_data_req,	// data master
	output fabric_ocp_pkg::ocp_rsp_t  o_data_rsp,
	output fabric_ocp_pkg::ocp_req_t  o_port_req [fabric_map_pkg::NPORTS],
	input  fabric_ocp_pkg::ocp_rsp_t  i_port_rsp [fabric_map_pkg::NPORTS]
);

	fabric_ocp_pkg::ocp_req_t   instr_port_req [fabric_map_pkg::NPORTS];
	fabric_ocp_pkg::ocp_rsp_t   instr_port_rsp [fabric_map_pkg::NPORTS];
	fabric_ocp_pkg::ocp_req_t   data_port_req  [fabric_map_pkg::NPORTS];
	fabric_ocp_pkg::ocp_rsp_t   data_port_rsp  [fabric_map_pkg::NPORTS];
	logic                       sel_data       [fabric_map_pkg::NPORTS];

	logic                       instr_act;
	logic                       data_act;
	fabric_map_pkg::port_idx_t  instr_portno;
	fabric_map_pkg::port_idx_t  data_portno;
	logic                       instr_grant;
	logic                       data_grant;
	logic                       instr_done;
	logic                       data_done;

	// ------------------------------------------------
	// master front ends

	fabric_master_port instr_port_i (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_req      (i_instr_req),
		.o_rsp      (o_instr_rsp),
		.o_port_req (instr_port_req),
		.i_port_rsp (instr_port_rsp),
		.o_act      (instr_act),
		.o_portno   (instr_portno),
		.i_grant    (instr_grant),
		.o_done     (instr_done)
	);

	fabric_master_port data_port_i (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_req      (i_data_req),
		.o_rsp      (o_data_rsp),
		.o_port_req (data_port_req),
		.i_port_rsp (data_port_rsp),
		.o_act      (data_act),
		.o_portno   (data_portno),
		.i_grant    (data_grant),
		.o_done     (data_done)
	);

	// ------------------------------------------------
	// one selector per slave port

	for (genvar p = 0; p < fabric_map_pkg::NPORTS; p++)
	begin : g_port
		fabric_slave_mux mux_i (
			.i_sel_data  (sel_data[p]),
			.i_instr_req (instr_port_req[p]),
			.i_data_req  (data_port_req[p]),
			.o_instr_rsp (instr_port_rsp[p]),
			.o_data_rsp  (data_port_rsp[p]),
			.o_port_req  (o_port_req[p]),
			.i_port_rsp  (i_port_rsp[p])
		);
	end

	fabric_control control_i (
		.clk            (clk),
		.i_reset        (i_reset),
		.i_instr_act    (instr_act),
		.i_data_act     (data_act),
		.i_instr_portno (instr_portno),
		.i_data_portno  (data_portno),
		.i_instr_done   (instr_done),
		.i_data_done    (data_done),
		.o_instr_grant  (instr_grant),
		.o_data_grant   (data_grant),
		.o_sel_data     (sel_data)
	);

endmodule

// File: design/fabric_control.sv
// ------------------------------------------------
// Fabric control block for per-port ownership and
// arbitration between instruction and data masters
// ------------------------------------------------

`timescale 1ns/100ps

module fabric_control (
	input  logic                       clk,
	input  logic                       i_reset,
	input  logic                       i_instr_act,
	input  logic                       i_data_act,
	input  fabric_map_pkg::port_idx_t  i_instr_portno,
	input  fabric_map_pkg::port_idx_t  i_data_portno,
	input  logic                       i_instr_done,
	input  logic                       i_data_done,
	output logic                       o_instr_grant,
	output logic                       o_data_grant,
	output logic                       o_sel_data [fabric_map_pkg::NPORTS]
);

	typedef enum logic [1:0]
	{
		OWN_FREE  = 2'd0,
		OWN_INSTR = 2'd1,
		OWN_DATA  = 2'd2
	} owner_t;

	owner_t  owner_q [fabric_map_pkg::NPORTS];
	owner_t  instr_own;	// owner of port wanted by instr
	owner_t  data_own;
	logic    instr_owns;	// instr holds some port
	logic    data_owns;
	logic    same_port;

	// ------------------------------------------------
	// owner lookup for requested ports

	always_comb
	begin
		instr_own  = OWN_FREE;
		data_own   = OWN_FREE;
		instr_owns = 1'b0;
		data_owns  = 1'b0;
		for (int p = 0; p < fabric_map_pkg::NPORTS; p++)
		begin
			if (i_instr_portno == fabric_map_pkg::port_idx_t'(p))
				instr_own = owner_q[p];
			if (i_data_portno == fabric_map_pkg::port_idx_t'(p))
				data_own = owner_q[p];
			instr_owns = instr_owns || (owner_q[p] == OWN_INSTR);
			data_owns  = data_owns || (owner_q[p] == OWN_DATA);
		end
	end

	assign same_port = i_data_act && (i_data_portno == i_instr_portno);

	// data wins a tie on a free port
	assign o_data_grant = i_data_act && (data_own == OWN_FREE || data_own == OWN_DATA);
	assign o_instr_grant = i_instr_act &&
		(instr_own == OWN_INSTR || (instr_own == OWN_FREE && !same_port));

	always_comb
	begin
		for (int p = 0; p < fabric_map_pkg::NPORTS; p++)
			o_sel_data[p] = (owner_q[p] == OWN_DATA) ||
				(owner_q[p] == OWN_FREE && o_data_grant &&
				i_data_portno == fabric_map_pkg::port_idx_t'(p));
	end

	// ------------------------------------------------
	// ownership registers

	// a port is claimed on grant, which is the accept cycle
	// or earlier when the slave stalls, and freed on response
	always_ff @(posedge clk)
	begin
		for (int p = 0; p < fabric_map_pkg::NPORTS; p++)
		begin
			if (i_reset)
				owner_q[p] <= OWN_FREE;
			else if (o_data_grant && i_data_portno == fabric_map_pkg::port_idx_t'(p))
				owner_q[p] <= OWN_DATA;
			else if (o_instr_grant && i_instr_portno == fabric_map_pkg::port_idx_t'(p))
				owner_q[p] <= OWN_INSTR;
			else if ((owner_q[p] == OWN_INSTR && i_instr_done) ||
				(owner_q[p] == OWN_DATA && i_data_done))
				owner_q[p] <= OWN_FREE;
		end
	end

	// a slave response implies the master still holds its port
	assert property (@(posedge clk) disable iff (i_reset) i_instr_done |-> instr_owns);
	assert property (@(posedge clk) disable iff (i_reset) i_data_done |-> data_owns);

endmodule

// File: design/fabric_map_pkg.sv
// ------------------------------------------------
// Fabric address map: port numbering and regions
// ------------------------------------------------

package fabric_map_pkg;

	localparam int NPORTS     = 5;
	localparam int LOCAL_BITS = 28;
	localparam int REGION_BITS = fabric_ocp_pkg::ADDR_WIDTH - LOCAL_BITS;

	typedef logic [2:0] port_idx_t;

	localparam port_idx_t PORT_NONE = 3'd7;	// unmapped address

	// top nibble picks the port, F is the I/O port
	function automatic port_idx_t decode_port(input logic [fabric_ocp_pkg::ADDR_WIDTH-1:0] addr);
		logic [REGION_BITS-1:0] region;
		region = addr[fabric_ocp_pkg::ADDR_WIDTH-1 -: REGION_BITS];
		case (region)
			4'h0: return 3'd0;
			4'h1: return 3'd1;
			4'h2: return 3'd2;
			4'h3: return 3'd3;
			4'hf: return 3'd4;
			default: return PORT_NONE;
		endcase
	endfunction

	// strip region bits
	function automatic logic [fabric_ocp_pkg::ADDR_WIDTH-1:0] local_addr(
		input logic [fabric_ocp_pkg::ADDR_WIDTH-1:0] addr);
		return {{REGION_BITS{1'b0}}, addr[LOCAL_BITS-1:0]};
	endfunction

endpackage

// File: design/fabric_master_port.sv
// ------------------------------------------------
// Fabric master front end: decode, route to a port,
// steer the response back, answer unmapped requests
// ------------------------------------------------

`timescale 1ns/100ps

module fabric_master_port (
	input  logic                       clk,
	input  logic                       i_reset,
	input  fabric_ocp_pkg::ocp_req_t   i_req,
	output fabric_ocp_pkg::ocp_rsp_t   o_rsp,
	output fabric_ocp_pkg::ocp_req_t   o_port_req [fabric_map_pkg::NPORTS],
	input  fabric_ocp_pkg::ocp_rsp_t   i_port_rsp [fabric_map_pkg::NPORTS],
	output logic                       o_act,
	output fabric_map_pkg::port_idx_t  o_portno,
	input  logic                       i_grant,
	output logic                       o_done
);

	logic                       cmd_valid;
	logic                       unmapped;
	logic                       none_accept;	// unmapped, taken locally
	logic                       port_accept;
	logic                       pend_q;		// waiting for slave response
	logic                       err_q;
	fabric_map_pkg::port_idx_t  port_q;		// port of outstanding command
	fabric_ocp_pkg::ocp_req_t   local_req;
	fabric_ocp_pkg::ocp_rsp_t   req_port_rsp;	// port being requested
	fabric_ocp_pkg::ocp_rsp_t   own_port_rsp;	// port holding our command

	assign cmd_valid   = (i_req.m_cmd != fabric_ocp_pkg::CMD_IDLE);
	assign o_portno    = fabric_map_pkg::decode_port(i_req.m_addr);
	assign unmapped    = (o_portno == fabric_map_pkg::PORT_NONE);
	assign o_act       = cmd_valid && !unmapped;
	assign none_accept = cmd_valid && unmapped;

	always_comb
	begin
		local_req = i_req;
		local_req.m_addr = fabric_map_pkg::local_addr(i_req.m_addr);
	end

	// ------------------------------------------------
	// port routing and response select

	always_comb
	begin
		req_port_rsp = '0;
		own_port_rsp = '0;
		for (int p = 0; p < fabric_map_pkg::NPORTS; p++)
		begin
			o_port_req[p] = '0;	// IDLE
			if (o_portno == fabric_map_pkg::port_idx_t'(p))
			begin
				req_port_rsp = i_port_rsp[p];
				if (o_act && i_grant)
					o_port_req[p] = local_req;
			end
			if (port_q == fabric_map_pkg::port_idx_t'(p))
				own_port_rsp = i_port_rsp[p];
		end
	end

	assign port_accept = o_act && i_grant && req_port_rsp.s_cmd_accept;
	assign o_done = pend_q && (own_port_rsp.s_resp != fabric_ocp_pkg::RESP_NULL);

	always_comb
	begin
		o_rsp = '0;
		o_rsp.s_cmd_accept = port_accept || none_accept;
		if (err_q)
			o_rsp.s_resp = fabric_ocp_pkg::RESP_ERR;
		else if (pend_q)
		begin
			o_rsp.s_resp = own_port_rsp.s_resp;
			o_rsp.s_data = own_port_rsp.s_data;
		end
	end

	// ------------------------------------------------
	// outstanding command state

	always_ff @(posedge clk)
	begin
		if (i_reset)
		begin
			pend_q <= 1'b0;
			err_q  <= 1'b0;
		end
		else
		begin
			err_q <= none_accept;	// ERR one cycle after local accept
			if (port_accept)
				pend_q <= 1'b1;
			else if (o_done)
				pend_q <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (port_accept)
			port_q <= o_portno;
	end

	// master must hold its command until accepted
	assert property (@(posedge clk) disable iff (i_reset)
		(cmd_valid && !o_rsp.s_cmd_accept) |=> $stable(i_req));

endmodule

// File: design/fabric_ocp_pkg.sv
// ------------------------------------------------
// OCP protocol definitions shared by the fabric
// command and response codes, request and response
// ------------------------------------------------

package fabric_ocp_pkg;

	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int BEN_WIDTH  = 4;

	// ------------------------------------------------
	// command and response codes

	typedef enum logic [2:0]
	{
		CMD_IDLE  = 3'b000,
		CMD_WRITE = 3'b001,
		CMD_READ  = 3'b010
	} ocp_cmd_t;

	typedef enum logic [1:0]
	{
		RESP_NULL = 2'b00,
		RESP_DVA  = 2'b01,	// data valid / write done
		RESP_ERR  = 2'b11
	} ocp_resp_t;

	// ------------------------------------------------
	// link payloads

	typedef struct packed
	{
		ocp_cmd_t               m_cmd;
		logic [ADDR_WIDTH-1:0]  m_addr;
		logic [DATA_WIDTH-1:0]  m_data;
		logic [BEN_WIDTH-1:0]   m_byte_en;
	} ocp_req_t;	// 71 bits

	typedef struct packed
	{
		logic                   s_cmd_accept;
		logic [DATA_WIDTH-1:0]  s_data;
		ocp_resp_t              s_resp;
	} ocp_rsp_t;	// 35 bits

endpackage

// File: design/fabric_slave_mux.sv
// ------------------------------------------------
// Fabric slave port selector between instruction
// and data masters, with response fan-back
// ------------------------------------------------

`timescale 1ns/100ps

module fabric_slave_mux (
	input  logic                      i_sel_data,	// 1: data master owns port
	input  fabric_ocp_pkg::ocp_req_t  i_instr_req,
	input  fabric_ocp_pkg::ocp_req_t  i_data_req,
	output fabric_ocp_pkg::ocp_rsp_t  o_instr_rsp,
	output fabric_ocp_pkg::ocp_rsp_t  o_data_rsp,
	output fabric_ocp_pkg::ocp_req_t  o_port_req,
	input  fabric_ocp_pkg::ocp_rsp_t  i_port_rsp
);

	// ------------------------------------------------
	// request path

	always_comb
	begin
		if (i_sel_data)
			o_port_req = i_data_req;
		else
			o_port_req = i_instr_req;
	end

	// ------------------------------------------------
	// accept and response back to owner only

	always_comb
	begin
		o_instr_rsp = '0;	// NULL, accept low
		o_data_rsp  = '0;
		if (i_sel_data)
			o_data_rsp = i_port_rsp;
		else
			o_instr_rsp = i_port_rsp;
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the fabric testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module fabric_tb -o fabric_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/fabric_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "PASS: all tests"; then
	exit 0
fi
exit 1

// File: sim.f
design/fabric_ocp_pkg.sv
design/fabric_map_pkg.sv
design/fabric_master_port.sv
design/fabric_slave_mux.sv
design/fabric_control.sv
design/fabric.sv
verif/fabric_checker.sv
verif/fabric_tb.sv

// File: verif/fabric_checker.sv
// ------------------------------------------------
// Fabric checker with a reference memory and the
// routing, ownership and response checks
// ------------------------------------------------

`timescale 1ns/100ps

module fabric_checker (
	input  logic                      clk,
	input  logic                      i_reset,
	input  fabric_ocp_pkg::ocp_req_t  i_instr_req,
	input  fabric_ocp_pkg::ocp_rsp_t  i_instr_rsp,
	input  fabric_ocp_pkg::ocp_req_t  i_data_req,
	input  fabric_ocp_pkg::ocp_rsp_t  i_data_rsp,
	input  fabric_ocp_pkg::ocp_req_t  i_port_req [fabric_map_pkg::NPORTS],
	input  fabric_ocp_pkg::ocp_rsp_t  i_port_rsp [fabric_map_pkg::NPORTS],
	output int                        o_errors,
	output int                        o_checked
);

	localparam int NPORTS = fabric_map_pkg::NPORTS;
	localparam int NONE   = -1;	// free port or unmapped address

	fabric_ocp_pkg::ocp_req_t   mreq [2];
	fabric_ocp_pkg::ocp_rsp_t   mrsp [2];
	logic [31:0]                ref_mem [NPORTS][16] = '{default: '0};
	int                         owner [NPORTS];	// master index or NONE
	logic                       exp_valid [2];
	logic                       exp_read  [2];
	logic                       err_due   [2];	// ERR must show this edge
	logic                       pending_q [2];	// held but not yet accepted
	fabric_ocp_pkg::ocp_resp_t  exp_resp  [2];
	logic [31:0]                exp_data  [2];
	logic                       in_reset_q = 1'b0;
	logic                       tie_q;
	int                         errors = 0;
	int                         checked = 0;

	assign mreq[0]   = i_instr_req;
	assign mreq[1]   = i_data_req;
	assign mrsp[0]   = i_instr_rsp;
	assign mrsp[1]   = i_data_rsp;
	assign o_errors  = errors;
	assign o_checked = checked;

	function automatic int region_port(input logic [31:0] addr);
		case (addr[31:28])
			4'h0: return 0;
			4'h1: return 1;
			4'h2: return 2;
			4'h3: return 3;
			4'hf: return 4;
			default: return NONE;
		endcase
	endfunction

	function automatic fabric_ocp_pkg::ocp_req_t localize(
		input fabric_ocp_pkg::ocp_req_t r);
		fabric_ocp_pkg::ocp_req_t  l;
		l = r;
		l.m_addr = {4'h0, r.m_addr[27:0]};
		return l;
	endfunction

	function automatic string link_name(input int m);
		return (m != 0) ? "o_data_rsp" : "o_instr_rsp";
	endfunction

	task automatic value_mismatch(input string sig, input logic [31:0] exp,
		input logic [31:0] got);
		$display("[FAIL] %0t %s expected %h got %h", $time, sig, exp, got);
		errors++;
	endtask

	task automatic protocol_error(input string msg);
		$display("%0t error: %s", $time, msg);
		errors++;
	endtask

	always @(posedge clk)
	begin
		int                        tgt [2];
		int                        owner_prev [NPORTS];
		logic                      accepted [2];
		logic                      matched;
		logic [3:0]                idx;
		fabric_ocp_pkg::ocp_req_t  want;
		if (i_reset || in_reset_q)
		begin
			for (int p = 0; p < NPORTS; p++)
				if (i_port_req[p].m_cmd != fabric_ocp_pkg::CMD_IDLE)
					value_mismatch($sformatf("o_port_req[%0d].m_cmd", p), 0,
						32'(i_port_req[p].m_cmd));
			for (int m = 0; m < 2; m++)
			begin
				if (mrsp[m].s_resp != fabric_ocp_pkg::RESP_NULL)
					value_mismatch({link_name(m), ".s_resp"}, 0, 32'(mrsp[m].s_resp));
				if (mrsp[m].s_cmd_accept)
					value_mismatch({link_name(m), ".s_cmd_accept"}, 0, 1);
			end
		end
		if (i_reset)
		begin
			in_reset_q = 1'b1;
			tie_q = 1'b0;
			for (int p = 0; p < NPORTS; p++)
				owner[p] = NONE;
			for (int m = 0; m < 2; m++)
			begin
				exp_valid[m] = 1'b0;
				err_due[m]   = 1'b0;
				pending_q[m] = 1'b0;
			end
		end
		else
		begin
			in_reset_q = 1'b0;
			for (int m = 0; m < 2; m++)
			begin
				tgt[m] = region_port(mreq[m].m_addr);
				accepted[m] = mreq[m].m_cmd != fabric_ocp_pkg::CMD_IDLE && mrsp[m].s_cmd_accept;
			end
			for (int p = 0; p < NPORTS; p++)
				owner_prev[p] = owner[p];

			// ------------------------------------------------
			// responses back at the masters
			for (int m = 0; m < 2; m++)
			begin
				if (mrsp[m].s_resp != fabric_ocp_pkg::RESP_NULL)
				begin
					checked++;
					if (!exp_valid[m])
						protocol_error($sformatf("%s responded with no command outstanding",
							link_name(m)));
					else if (mrsp[m].s_resp != exp_resp[m])
						value_mismatch({link_name(m), ".s_resp"}, 32'(exp_resp[m]),
							32'(mrsp[m].s_resp));
					else if (exp_read[m] && exp_resp[m] == fabric_ocp_pkg::RESP_DVA &&
						mrsp[m].s_data != exp_data[m])
						value_mismatch({link_name(m), ".s_data"}, exp_data[m], mrsp[m].s_data);
					exp_valid[m] = 1'b0;
					for (int p = 0; p < NPORTS; p++)
						if (owner[p] == m)
							owner[p] = NONE;
				end
				else if (err_due[m])
				begin
					value_mismatch({link_name(m), ".s_resp"}, 32'(fabric_ocp_pkg::RESP_ERR), 0);
					exp_valid[m] = 1'b0;
				end
				err_due[m] = 1'b0;
			end

			// every port command must come from a master mapped to it
			for (int p = 0; p < NPORTS; p++)
				if (i_port_req[p].m_cmd != fabric_ocp_pkg::CMD_IDLE)
				begin
					matched = 1'b0;
					for (int m = 0; m < 2; m++)
						if (mreq[m].m_cmd != fabric_ocp_pkg::CMD_IDLE && tgt[m] == p &&
							i_port_req[p] == localize(mreq[m]))
							matched = 1'b1;
					if (!matched)
						protocol_error($sformatf("port %0d shows a command no master sent to it",
							p));
				end

			// same-cycle tie on a free port goes to data
			if (mreq[0].m_cmd != fabric_ocp_pkg::CMD_IDLE && !pending_q[0] &&
				mreq[1].m_cmd != fabric_ocp_pkg::CMD_IDLE && !pending_q[1] &&
				tgt[0] == tgt[1] && tgt[0] != NONE && owner_prev[tgt[0]] == NONE)
				tie_q = 1'b1;
			if (tie_q && accepted[0] && !accepted[1])
				protocol_error("instruction master accepted ahead of the data master on a tie");
			if (accepted[1])
				tie_q = 1'b0;

			// ------------------------------------------------
			// accepted commands
			for (int m = 0; m < 2; m++)
			begin
				if (accepted[m])
				begin
					if (exp_valid[m])
						protocol_error($sformatf("%s accepted a second command", link_name(m)));
					exp_valid[m] = 1'b1;
					exp_read[m]  = mreq[m].m_cmd == fabric_ocp_pkg::CMD_READ;
					if (tgt[m] == NONE)
					begin
						exp_resp[m] = fabric_ocp_pkg::RESP_ERR;
						err_due[m]  = 1'b1;	// ERR one cycle later
					end
					else
					begin
						exp_resp[m] = fabric_ocp_pkg::RESP_DVA;
						if (owner_prev[tgt[m]] != NONE && owner_prev[tgt[m]] != m)
							protocol_error($sformatf(
								"%s accepted on port %0d owned by the other master",
								link_name(m), tgt[m]));
						if (m == 1 && accepted[0] && tgt[0] == tgt[1])
							protocol_error($sformatf(
								"both masters accepted on port %0d in one cycle", tgt[m]));
						want = localize(mreq[m]);
						if (!i_port_rsp[tgt[m]].s_cmd_accept)
							protocol_error($sformatf(
								"master accept without accept at port %0d", tgt[m]));
						if (i_port_req[tgt[m]].m_addr != want.m_addr)
							value_mismatch($sformatf("o_port_req[%0d].m_addr", tgt[m]),
								want.m_addr, i_port_req[tgt[m]].m_addr);
						if (i_port_req[tgt[m]].m_data != want.m_data)
							value_mismatch($sformatf("o_port_req[%0d].m_data", tgt[m]),
								want.m_data, i_port_req[tgt[m]].m_data);
						if (i_port_req[tgt[m]].m_byte_en != want.m_byte_en)
							value_mismatch($sformatf("o_port_req[%0d].m_byte_en", tgt[m]),
								32'(want.m_byte_en), 32'(i_port_req[tgt[m]].m_byte_en));
						idx = want.m_addr[5:2];
						if (exp_read[m])
							exp_data[m] = ref_mem[tgt[m]][idx];
						else
							for (int b = 0; b < 4; b++)
								if (want.m_byte_en[b])
									ref_mem[tgt[m]][idx][8*b +: 8] = want.m_data[8*b +: 8];
						owner[tgt[m]] = m;
					end
				end
				pending_q[m] = mreq[m].m_cmd != fabric_ocp_pkg::CMD_IDLE && !accepted[m];
			end
		end
	end

endmodule

// File: verif/fabric_tb.sv
// ------------------------------------------------
// Fabric testbench: clock, reset, random masters
// and slave memory models
// ------------------------------------------------

`timescale 1ns/100ps

module fabric_tb;

	localparam int NPORTS     = fabric_map_pkg::NPORTS;
	localparam int NCMD       = 400;	// per master
	localparam int CLK_PERIOD = 8;
	localparam int HOLD       = 1;	// input drive delay after edge
	localparam int WATCHDOG   = 2 * NCMD * 12 * CLK_PERIOD;
	localparam logic [31:0] SEED = 32'h8fb3_5299;

	logic                      clk;
	logic                      reset;
	fabric_ocp_pkg::ocp_req_t  mreq [2];	// 0 instr, 1 data
	fabric_ocp_pkg::ocp_rsp_t  mrsp [2];
	fabric_ocp_pkg::ocp_req_t  port_req [NPORTS];
	fabric_ocp_pkg::ocp_rsp_t  port_rsp [NPORTS] = '{default: '0};
	int                        chk_errors;
	int                        chk_checked;
	int                        tb_errors = 0;

	// slave model state
	logic                      busy      [NPORTS];
	int                        acc_wait  [NPORTS];	// cycles until accept
	int                        resp_wait [NPORTS];	// cycles until response
	logic [31:0]               rdata     [NPORTS];
	logic [31:0]               smem      [NPORTS][16] = '{default: '0};

	fabric dut_i (
		.clk         (clk),
		.i_reset     (reset),
		.i_instr_req (mreq[0]),
		.o_instr_rsp (mrsp[0]),
		.i_data_req  (mreq[1]),
		.o_data_rsp  (mrsp[1]),
		.o_port_req  (port_req),
		.i_port_rsp  (port_rsp)
	);

	fabric_checker checker_i (
		.clk         (clk),
		.i_reset     (reset),
		.i_instr_req (mreq[0]),
		.i_instr_rsp (mrsp[0]),
		.i_data_req  (mreq[1]),
		.i_data_rsp  (mrsp[1]),
		.i_port_req  (port_req),
		.i_port_rsp  (port_rsp),
		.o_errors    (chk_errors),
		.o_checked   (chk_checked)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ------------------------------------------------
	// slave memory models

	always @(posedge clk)
	begin : slave_models
		fabric_ocp_pkg::ocp_rsp_t  nxt [NPORTS];
		logic [3:0]                idx;
		for (int p = 0; p < NPORTS; p++)
		begin
			nxt[p] = '0;
			idx = port_req[p].m_addr[5:2];
			if (reset)
			begin
				busy[p]     = 1'b0;
				acc_wait[p] = $urandom % 3;
			end
			else if (!busy[p])
			begin
				if (port_req[p].m_cmd != fabric_ocp_pkg::CMD_IDLE && port_rsp[p].s_cmd_accept)
				begin
					busy[p]      = 1'b1;
					resp_wait[p] = 1 + $urandom % 3;
					rdata[p]     = '0;
					if (port_req[p].m_cmd == fabric_ocp_pkg::CMD_WRITE)
					begin
						for (int b = 0; b < 4; b++)
							if (port_req[p].m_byte_en[b])
								smem[p][idx][8*b +: 8] = port_req[p].m_data[8*b +: 8];
					end
					else
						rdata[p] = smem[p][idx];
				end
				else if (port_req[p].m_cmd != fabric_ocp_pkg::CMD_IDLE && acc_wait[p] != 0)
					acc_wait[p] = acc_wait[p] - 1;
			end
			else if (port_rsp[p].s_resp != fabric_ocp_pkg::RESP_NULL)
			begin
				busy[p]     = 1'b0;	// response went out last cycle
				acc_wait[p] = $urandom % 3;
			end
			else
				resp_wait[p] = resp_wait[p] - 1;

			if (!reset)
			begin
				nxt[p].s_cmd_accept = !busy[p] && acc_wait[p] == 0;
				if (busy[p] && resp_wait[p] == 1)
				begin
					nxt[p].s_resp = fabric_ocp_pkg::RESP_DVA;
					nxt[p].s_data = rdata[p];
				end
			end
		end
		#HOLD;
		for (int p = 0; p < NPORTS; p++)
			port_rsp[p] = nxt[p];
	end

	// ------------------------------------------------
	// master stimulus

	function automatic fabric_ocp_pkg::ocp_req_t random_cmd();
		fabric_ocp_pkg::ocp_req_t  r;
		logic [3:0]                region;
		logic [3:0]                idx;
		int                        sel;
		if ($urandom % 10 == 0)
			region = 4'(4 + $urandom % 11);	// 4..E, unmapped
		else
		begin
			sel = $urandom % 5;
			region = (sel == 4) ? 4'hf : 4'(sel);
		end
		idx = 4'($urandom % 16);	// small pool so reads hit writes
		r.m_cmd = ($urandom % 2 != 0) ? fabric_ocp_pkg::CMD_WRITE : fabric_ocp_pkg::CMD_READ;
		r.m_addr = {region, 22'd0, idx, 2'b00};
		r.m_data = $urandom;
		r.m_byte_en = (r.m_cmd == fabric_ocp_pkg::CMD_WRITE) ? 4'($urandom) : 4'hf;
		return r;
	endfunction

	task automatic run_master(input int m);
		fabric_ocp_pkg::ocp_req_t  req;
		int                        n;
		for (n = 0; n < NCMD; n++)
		begin
			req = random_cmd();
			repeat ($urandom % 2) @(posedge clk);
			#HOLD;
			mreq[m] = req;
			@(posedge clk);
			while (!mrsp[m].s_cmd_accept)
				@(posedge clk);
			#HOLD;
			mreq[m] = '0;	// IDLE until response
			@(posedge clk);
			while (mrsp[m].s_resp == fabric_ocp_pkg::RESP_NULL)
				@(posedge clk);
		end
	endtask

	initial
	begin
		#(WATCHDOG);
		$display("watchdog expired after %0d ns, masters did not finish", WATCHDOG);
		$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		void'($urandom(SEED));
		reset   = 1'b1;
		mreq[0] = '0;
		mreq[1] = '0;
		repeat (5) @(posedge clk);
		#HOLD;
		reset = 1'b0;
		repeat (2) @(posedge clk);
		fork
			run_master(0);
			run_master(1);
		join
		repeat (4) @(posedge clk);
		if (chk_checked != 2 * NCMD)
		begin
			$display("only %0d of %0d responses were seen", chk_checked, 2 * NCMD);
			tb_errors++;
		end
		$display("checker errors: %0d, testbench errors: %0d, responses checked: %0d",
			chk_errors, tb_errors, chk_checked);
		if (chk_errors + tb_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
